//--- hw/uart_pkg.sv
package uart_pkg;

  // line timing
  localparam int unsigned clk_freq  = 50_000_000;
  localparam int unsigned baud_rate = 115_200;
  localparam int unsigned baud_div  = clk_freq / baud_rate;

  // holds a count up to baud_div - 1
  localparam int baud_cnt_w = $clog2(baud_div);

  // word sizes
  localparam int cmd_w  = 16;
  localparam int data_w = 8;

  // start + 8 data + parity + stop
  localparam int frame_bits = 11;
  localparam int bit_cnt_w  = $clog2(frame_bits);

  // byte from the command sequencer to the transmitter
  typedef struct packed {
    logic [data_w-1:0] data;
  } tx_byte_t;

  // one received frame
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              parity_err;
  } rx_byte_t;

endpackage

//--- hw/uart_baud_gen.sv
module uart_baud_gen (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic bit_tick,
  output logic mid_tick
);

  import uart_pkg::*;

  logic [baud_cnt_w-1:0] cnt;

  // restarts from zero whenever run drops
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!run || bit_tick) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // last cycle of a bit period
  assign bit_tick = run && (cnt == baud_cnt_w'(baud_div - 1));

  // halfway into the bit
  assign mid_tick = run && (cnt == baud_cnt_w'(baud_div / 2 - 1));

endmodule

//--- hw/uart_tx.sv
module uart_tx (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               tx_start,
  input  uart_pkg::tx_byte_t tx_byte,
  output logic               tx,
  output logic               tx_busy,
  output logic               tx_done
);

  import uart_pkg::*;

  logic                  bit_tick;
  logic                  load;
  logic [frame_bits-2:0] shreg;
  logic [bit_cnt_w-1:0]  bit_cnt;

  // bit period runs only during a frame
  uart_baud_gen baud_gen_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (tx_busy),
    .bit_tick (bit_tick),
    .mid_tick ()
  );

  assign load = tx_start && !tx_busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx      <= 1'b1;
      tx_busy <= 1'b0;
      tx_done <= 1'b0;
      bit_cnt <= '0;
    end else begin
      tx_done <= 1'b0;
      if (load) begin
        // start bit goes out right away
        tx      <= 1'b0;
        tx_busy <= 1'b1;
        bit_cnt <= '0;
      end else if (tx_busy && bit_tick) begin
        if (bit_cnt == bit_cnt_w'(frame_bits - 1)) begin
          // end of stop bit
          tx      <= 1'b1;
          tx_busy <= 1'b0;
          tx_done <= 1'b1;
        end else begin
          tx      <= shreg[0];
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end
  end

  // stop, odd parity, data lsb first; ones fill in behind
  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= {1'b1, ~^tx_byte.data, tx_byte.data};
    end else if (tx_busy && bit_tick) begin
      shreg <= {1'b1, shreg[frame_bits-2:1]};
    end
  end

  // line idles high between frames
  a_idle_high : assert property (
    @(posedge clk) disable iff (!rst_n)
    !tx_busy |-> tx
  );

endmodule

//--- hw/uart_rx.sv
module uart_rx (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rx,
  output logic               read_rdy,
  output uart_pkg::rx_byte_t read
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_bits
  } state_t;

  state_t               state;
  logic [1:0]           rx_sync;
  logic                 rx_prev;
  logic                 rx_s;
  logic                 run;
  logic                 mid_tick;
  logic                 last_bit;
  logic [bit_cnt_w-1:0] bit_cnt;
  logic [data_w:0]      shreg;

  assign rx_s = rx_sync[1];
  assign run  = (state != st_idle);

  // bit period restarts at each start edge
  uart_baud_gen baud_gen_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .bit_tick (),
    .mid_tick (mid_tick)
  );

  // two flops against metastability, one more for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;
      rx_prev <= 1'b1;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      rx_prev <= rx_s;
    end
  end

  // stop bit comes after data and parity
  assign last_bit = (bit_cnt == bit_cnt_w'(frame_bits - 2));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      bit_cnt  <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      case (state)
        st_idle: begin
          if (rx_prev && !rx_s) begin
            state <= st_start;
          end
        end
        st_start: begin
          // glitch if the line is back high at mid start bit
          if (mid_tick) begin
            bit_cnt <= '0;
            state   <= rx_s ? st_idle : st_bits;
          end
        end
        st_bits: begin
          if (mid_tick) begin
            if (last_bit) begin
              state    <= st_idle;
              read_rdy <= 1'b1;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // data lsb first, parity lands on top
  always_ff @(posedge clk) begin
    if (state == st_bits && mid_tick) begin
      if (last_bit) begin
        read.data       <= shreg[data_w-1:0];
        read.parity_err <= ~(^shreg) | ~rx_s;
      end else begin
        shreg <= {rx_s, shreg[data_w:1]};
      end
    end
  end

  a_rdy_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy
  );

endmodule

//--- hw/uart_cmd_ctrl.sv
module uart_cmd_ctrl (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [uart_pkg::cmd_w-1:0] cmd_in,
  input  logic                      cmd_vld,
  output logic                      cmd_rdy,
  input  logic                      tx_done,
  output logic                      tx_start,
  output uart_pkg::tx_byte_t        tx_byte
);

  import uart_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_high,
    st_low
  } state_t;

  state_t           state;
  logic [cmd_w-1:0] cmd_q;
  logic             accept;

  assign cmd_rdy = (state == st_idle);
  assign accept  = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= st_idle;
      tx_start <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            state    <= st_high;
            tx_start <= 1'b1;
          end
        end
        st_high: begin
          // first frame out, low byte next
          if (tx_done) begin
            state    <= st_low;
            tx_start <= 1'b1;
          end
        end
        st_low: begin
          if (tx_done) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

  // high byte first
  assign tx_byte.data = (state == st_low) ? cmd_q[data_w-1:0] : cmd_q[cmd_w-1 -: data_w];

  a_start_busy : assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !cmd_rdy
  );

endmodule

//--- hw/uart_bridge.sv
module uart_bridge (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [uart_pkg::cmd_w-1:0] cmd_in,
  input  logic                       cmd_vld,
  input  logic                       rx,
  output logic                       cmd_rdy,
  output logic                       tx,
  output logic                       read_rdy,
  output uart_pkg::rx_byte_t         read
);

  import uart_pkg::*;

  logic     tx_start;
  logic     tx_done;
  tx_byte_t tx_byte;

  uart_cmd_ctrl cmd_ctrl_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_done  (tx_done),
    .tx_start (tx_start),
    .tx_byte  (tx_byte)
  );

  uart_tx tx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (),
    .tx_done  (tx_done)
  );

  // receive side is independent of the command path
  uart_rx rx_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .read_rdy (read_rdy),
    .read     (read)
  );

endmodule

//--- verification/uart_bridge_tb.sv
module uart_bridge_tb;

  import uart_pkg::*;

  logic             clk;
  logic             rst_n;
  logic [cmd_w-1:0] cmd_in;
  logic             cmd_vld;
  logic             rx;
  logic             cmd_rdy;
  logic             tx;
  logic             read_rdy;
  rx_byte_t         read;

  int rdy_pulses = 0;

  uart_bridge uart_bridge_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .rx       (rx),
    .cmd_rdy  (cmd_rdy),
    .tx       (tx),
    .read_rdy (read_rdy),
    .read     (read)
  );

  always #50 clk = ~clk;

  // every read_rdy pulse seen on a clock edge
  always @(posedge clk) begin
    if (rst_n && read_rdy) begin
      rdy_pulses <= rdy_pulses + 1;
    end
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else
      report_failure($sformatf("ERROR: %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // one when the data has an even count of ones
  function automatic logic odd_parity_bit(input logic [data_w-1:0] b);
    return ($countones(b) % 2) == 0;
  endfunction

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
  endtask

  task automatic wait_cmd_rdy(input int limit);
    int n = 0;
    while (!cmd_rdy) begin
      @(posedge clk);
      #1;
      n++;
      if (n > limit) report_failure("cmd_rdy did not return high in time");
    end
  endtask

  task automatic send_cmd(input logic [cmd_w-1:0] value);
    @(posedge clk);
    #1;
    wait_cmd_rdy(4 * frame_bits * baud_div);
    cmd_in  = value;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  // start bit is seen half a cycle in, then every sample lands mid-bit
  task automatic capture_frame(input int max_wait, output logic [data_w-1:0] data,
                               output logic parity, output logic stop);
    int n = 0;
    while (tx) begin
      @(negedge clk);
      n++;
      if (n > max_wait) report_failure($sformatf("no start bit on tx within %0d cycles", max_wait));
    end
    repeat (baud_div / 2) @(negedge clk);
    compare_hex("tx start bit", 32'(tx), 32'(0));
    for (int i = 0; i < data_w; i++) begin
      repeat (baud_div) @(negedge clk);
      data[i] = tx;
    end
    repeat (baud_div) @(negedge clk);
    parity = tx;
    repeat (baud_div) @(negedge clk);
    stop = tx;
  endtask

  task automatic verify_tx_byte(input logic [data_w-1:0] exp, input int max_wait);
    logic [data_w-1:0] data;
    logic              parity;
    logic              stop;
    capture_frame(max_wait, data, parity, stop);
    compare_hex("tx data", 32'(data), 32'(exp));
    compare_hex("tx parity", 32'(parity), 32'(odd_parity_bit(exp)));
    compare_hex("tx stop bit", 32'(stop), 32'(1));
  endtask

  // high byte 2 cycles after acceptance, low byte after at most 2 idle cycles
  task automatic expect_command(input logic [cmd_w-1:0] cmd);
    verify_tx_byte(cmd[cmd_w-1 -: data_w], 2);
    compare_hex("cmd_rdy", 32'(cmd_rdy), 32'(0));
    verify_tx_byte(cmd[data_w-1:0], baud_div - baud_div / 2 + 2);
  endtask

  task automatic watch_tx_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      compare_hex("tx", 32'(tx), 32'(1));
    end
  endtask

  task automatic drive_frame(input logic [data_w-1:0] data, input logic bad_parity,
                             input logic stop);
    logic [frame_bits-1:0] bits;
    bits = {stop, odd_parity_bit(data) ^ bad_parity, data, 1'b0};
    @(posedge clk);
    #1;
    for (int i = 0; i < frame_bits; i++) begin
      rx = bits[i];
      repeat (baud_div) @(posedge clk);
      #1;
    end
    rx = 1'b1;
  endtask

  task automatic expect_read(input logic [data_w-1:0] exp_data, input logic exp_err);
    int n = 0;
    int pulses_before;
    pulses_before = rdy_pulses;
    while (!read_rdy) begin
      @(negedge clk);
      n++;
      if (n > (frame_bits + 1) * baud_div) report_failure("read_rdy never pulsed for a frame");
    end
    compare_hex("read.data", 32'(read.data), 32'(exp_data));
    compare_hex("read.parity_err", 32'(read.parity_err), 32'(exp_err));
    repeat (4) @(negedge clk);
    compare_hex("read_rdy pulse count", 32'(rdy_pulses), 32'(pulses_before + 1));
  endtask

  task automatic receive_byte(input logic [data_w-1:0] data, input logic bad_parity,
                              input logic stop);
    fork
      drive_frame(data, bad_parity, stop);
      expect_read(data, bad_parity || !stop);
    join
  endtask

  task automatic reset_state();
    @(negedge clk);
    compare_hex("tx", 32'(tx), 32'(1));
    compare_hex("cmd_rdy", 32'(cmd_rdy), 32'(1));
    compare_hex("read_rdy", 32'(read_rdy), 32'(0));
  endtask

  task automatic single_command();
    logic [cmd_w-1:0] cmd;
    cmd = cmd_w'($urandom());
    send_cmd(cmd);
    expect_command(cmd);
    wait_cmd_rdy(baud_div);
  endtask

  // a pulse in the middle of the first frame must be dropped
  task automatic refuse_busy_command();
    logic [cmd_w-1:0] cmd;
    cmd = cmd_w'($urandom());
    send_cmd(cmd);
    compare_hex("cmd_rdy", 32'(cmd_rdy), 32'(0));
    fork
      expect_command(cmd);
      begin
        repeat (baud_div) @(posedge clk);
        #1;
        compare_hex("cmd_rdy", 32'(cmd_rdy), 32'(0));
        cmd_in  = ~cmd;
        cmd_vld = 1'b1;
        @(posedge clk);
        #1;
        cmd_vld = 1'b0;
        repeat (frame_bits * baud_div) @(posedge clk);
        #1;
        compare_hex("cmd_rdy", 32'(cmd_rdy), 32'(0));
      end
    join
    wait_cmd_rdy(baud_div);
    watch_tx_idle(4 * baud_div);
  endtask

  task automatic good_frames();
    receive_byte(data_w'($urandom()), 1'b0, 1'b1);
    receive_byte(data_w'($urandom()), 1'b0, 1'b1);
  endtask

  task automatic bad_frames();
    receive_byte(data_w'($urandom()), 1'b1, 1'b1);
    receive_byte(data_w'($urandom()), 1'b0, 1'b0);
  endtask

  task automatic interleave_traffic();
    logic [cmd_w-1:0]  cmds [3];
    logic [data_w-1:0] bytes_in [3];
    for (int i = 0; i < 3; i++) begin
      cmds[i]     = cmd_w'($urandom());
      bytes_in[i] = data_w'($urandom());
    end
    fork
      for (int i = 0; i < 3; i++) begin
        send_cmd(cmds[i]);
        expect_command(cmds[i]);
        wait_cmd_rdy(baud_div);
      end
      for (int i = 0; i < 3; i++) begin
        receive_byte(bytes_in[i], 1'b0, 1'b1);
      end
    join
  endtask

  initial begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    void'($urandom(32'he4e7_e09d));
    apply_reset();
    reset_state();
    single_command();
    refuse_busy_command();
    good_frames();
    bad_frames();
    interleave_traffic();
    watch_tx_idle(baud_div);
    // 2 good, 2 bad and 3 interleaved frames
    compare_hex("read_rdy pulse count", 32'(rdy_pulses), 32'(7));
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- files.f
hw/uart_pkg.sv
hw/uart_baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_cmd_ctrl.sv
hw/uart_bridge.sv
verification/uart_bridge_tb.sv

//--- Makefile
TOP := uart_bridge_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
